// File: cart_pkg.sv
/*
 * Shared types for the cartridge loading path.
 * Download beats are 16 bits wide with a byte address, so word
 * addresses are always even. Header info addresses assume a 512-byte
 * copier header in front of the ROM image.
 */
`default_nettype none

package cart_pkg;

	// ======================================================================
	// Bus and result structures
	// ======================================================================

	typedef struct packed {
		logic        wr;
		logic [24:0] addr;
		logic [15:0] data;
	} dl_word_t;

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic [3:0]  ram_size;
		logic        pal;
	} cart_info_t;

	typedef struct packed {
		logic        enable;
		logic [23:0] split;
		logic [23:0] rmask;
	} mirror_cfg_t;

	typedef logic [23:0] rom_addr_t;

	// Menu selections
	typedef enum logic [2:0] {HDR_AUTO, HDR_NONE, HDR_LOROM, HDR_HIROM, HDR_EXHIROM} hdr_mode_e;
	typedef enum logic [1:0] {REG_AUTO, REG_NTSC, REG_PAL} region_sel_e;
	typedef enum logic [1:0] {FILL_9966, FILL_00FF, FILL_55, FILL_FF} fill_pattern_e;

	// ======================================================================
	// Header layout
	// ======================================================================

	localparam int unsigned HDR_SKIP = 512;

	// Size word of the internal header, RAM size word follows 2 bytes up
	localparam logic [24:0] LOROM_INFO_ADDR   = 25'(32'h00_7FD6 + HDR_SKIP);
	localparam logic [24:0] HIROM_INFO_ADDR   = 25'(32'h00_FFD6 + HDR_SKIP);
	localparam logic [24:0] EXHIROM_INFO_ADDR = 25'(32'h40_FFD6 + HDR_SKIP);

	// 4 Mbyte when the file says nothing
	localparam logic [3:0] ROM_SIZE_DEFAULT = 4'd12;

	localparam logic [23:0] MIRROR_MIN_SPLIT = 24'h04_0000;

endpackage

`default_nettype wire

// File: cart_header_parser.sv
/*
 * Header capture for cartridge downloads.
 * Every beat seen while dl_active is high counts as part of the
 * cartridge file. Type and size masks are published only at dl_end,
 * so a download that is cut short still publishes what was seen.
 * Region changes take effect only while no download runs.
 */
`timescale 1ns/10ps
`default_nettype none

module cart_header_parser import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        dl_active,
	input  dl_word_t    dl,
	input  hdr_mode_e   hdr_mode,
	input  region_sel_e region_sel,
	output cart_info_t  cart_info,
	output logic        dl_end
);

	logic        dl_active_q;
	logic [7:0]  rom_type;
	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;
	logic [24:0] info_addr;
	logic        info_by_mode;
	logic        beat;

	assign beat = dl_active && dl.wr;

	// Where the forced modes keep their size word
	always_comb begin
		info_by_mode = 1'b1;
		case (hdr_mode)
			HDR_LOROM:   info_addr = LOROM_INFO_ADDR;
			HDR_HIROM:   info_addr = HIROM_INFO_ADDR;
			HDR_EXHIROM: info_addr = EXHIROM_INFO_ADDR;
			default: begin
				info_addr    = '0;
				info_by_mode = 1'b0;
			end
		endcase
	end

	// End of download strobe
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_active_q <= 1'b0;
			dl_end      <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			dl_end      <= dl_active_q && !dl_active;
		end
	end

	// Header fields from the stream
	always_ff @(posedge clk_sys) begin
		if (beat) begin
			if (dl.addr == 25'd0) begin
				rom_size <= ROM_SIZE_DEFAULT;
				ram_size <= 4'd0;
				if (hdr_mode == HDR_AUTO && dl.data[7:0] != 8'd0)
					{ram_size, rom_size} <= dl.data[7:0];
				case (hdr_mode)
					HDR_NONE, HDR_LOROM: rom_type <= 8'd0;
					HDR_HIROM:           rom_type <= 8'd1;
					HDR_EXHIROM:         rom_type <= 8'd2;
					default:             rom_type <= dl.data[15:8];
				endcase
			end
			if (info_by_mode) begin
				if (dl.addr == info_addr)
					rom_size <= dl.data[11:8];
				if (dl.addr == info_addr + 25'd2)
					ram_size <= dl.data[3:0];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_info  <= '0;
			rom_region <= 1'b0;
		end else begin
			if (beat && dl.addr == 25'd2)
				rom_region <= dl.data[8];

			if (dl_end) begin
				cart_info.rom_type <= rom_type;
				cart_info.rom_mask <= (24'd1024 << rom_size) - 24'd1;
				cart_info.ram_mask <= (ram_size != 4'd0) ?
					(24'd1024 << ram_size) - 24'd1 : 24'd0;
				cart_info.ram_size <= ram_size;
			end

			if (!dl_active) begin
				case (region_sel)
					REG_NTSC: cart_info.pal <= 1'b0;
					REG_PAL:  cart_info.pal <= 1'b1;
					default:  cart_info.pal <= rom_region;
				endcase
			end
		end
	end

	a_dl_end_single : assert property (@(posedge clk_sys) disable iff (RESET)
		dl_end |=> !dl_end)
		else $error("dl_end held for more than one cycle");

endmodule

`default_nettype wire

// File: rom_mirror_config.sv
/*
 * Mirror window for ROM images whose size is not a power of two.
 * The file size is read from the download header words at byte
 * addresses 8 and 10. The window is cleared at each download start
 * and stays off for power-of-two sizes.
 */
`timescale 1ns/10ps
`default_nettype none

module rom_mirror_config import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        dl_active,
	input  logic        dl_end,
	input  dl_word_t    dl,
	output mirror_cfg_t mirror
);

	logic        dl_active_q;
	logic        dl_start;
	logic [23:0] file_sz;
	logic [23:0] split_sel;
	logic        not_pow2;

	assign dl_start = dl_active && !dl_active_q;
	assign not_pow2 = |(file_sz & (file_sz - 24'd1));

	// Highest size bit from 23 down to 19 wins
	always_comb begin
		split_sel = MIRROR_MIN_SPLIT;
		for (int b = 19; b <= 23; b++) begin
			if (file_sz[b])
				split_sel = 24'd1 << b;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_active_q   <= 1'b0;
			file_sz       <= '0;
			mirror.enable <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			if (dl_start) begin
				file_sz       <= '0;
				mirror.enable <= 1'b0;
			end
			if (dl_active && dl.wr) begin
				if (dl.addr == 25'd8)
					file_sz[15:0] <= dl.data;
				if (dl.addr == 25'd10)
					file_sz[23:16] <= dl.data[7:0];
			end
			if (dl_end && not_pow2)
				mirror.enable <= 1'b1;
		end
	end

	// Window bounds only matter once enable is set
	always_ff @(posedge clk_sys) begin
		if (dl_end && not_pow2) begin
			mirror.split <= split_sel;
			mirror.rmask <= file_sz - split_sel - 24'd1;
		end
	end

endmodule

`default_nettype wire

// File: rom_addr_mapper.sv
/*
 * Two-stage ROM address translation with credit flow control.
 * The requester must hold a credit for every req_valid and starts
 * with MAP_CREDITS of them. With response credits in hand a result
 * leaves 2 cycles after its request, otherwise it waits in order in
 * a MAP_CREDITS-deep buffer. The mirror window must be stable while
 * lookups are in flight.
 */
`timescale 1ns/10ps
`default_nettype none

module rom_addr_mapper import cart_pkg::*; #(
	parameter int MAP_CREDITS = 4
) (
	input  logic        clk_sys,
	input  logic        RESET,
	input  mirror_cfg_t mirror,
	input  logic        req_valid,
	input  rom_addr_t   req_addr,
	output logic        req_credit,
	output logic        rsp_valid,
	output rom_addr_t   rsp_addr,
	input  logic        rsp_credit
);

	localparam int PTR_W = (MAP_CREDITS > 1) ? $clog2(MAP_CREDITS) : 1;
	localparam int CNT_W = $clog2(MAP_CREDITS + 1);

	logic             s1_valid;
	logic             s1_hit;
	rom_addr_t        s1_addr;
	logic             s2_valid;
	rom_addr_t        s2_addr;
	rom_addr_t        buf_mem [MAP_CREDITS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] buf_cnt;
	logic [CNT_W-1:0] rsp_cred;
	logic             buf_empty;
	logic             has_cred;
	logic             push;
	logic             pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(MAP_CREDITS - 1)) ? '0 : p + 1'b1;
	endfunction

	assign buf_empty = (buf_cnt == '0);
	assign has_cred  = (rsp_cred != '0);

	// Buffered results go first, stage 2 bypasses an empty buffer
	assign rsp_valid = has_cred && (s2_valid || !buf_empty);
	assign rsp_addr  = buf_empty ? s2_addr : buf_mem[rd_ptr];
	assign pop       = has_cred && !buf_empty;
	assign push      = s2_valid && !(buf_empty && has_cred);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			s1_valid   <= 1'b0;
			s2_valid   <= 1'b0;
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			buf_cnt    <= '0;
			rsp_cred   <= CNT_W'(MAP_CREDITS);
			req_credit <= 1'b0;
		end else begin
			s1_valid <= req_valid;
			s2_valid <= s1_valid;
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			buf_cnt    <= buf_cnt + CNT_W'(push) - CNT_W'(pop);
			rsp_cred   <= rsp_cred + CNT_W'(rsp_credit) - CNT_W'(rsp_valid);
			req_credit <= rsp_valid;
		end
	end

	// Stage 1 window test, stage 2 fold into the mirror
	always_ff @(posedge clk_sys) begin
		s1_addr <= req_addr;
		s1_hit  <= mirror.enable && |(req_addr & mirror.split);
		s2_addr <= s1_hit ? (mirror.split | (s1_addr & mirror.rmask)) : s1_addr;
		if (push)
			buf_mem[wr_ptr] <= s2_addr;
	end

	a_rsp_needs_credit : assert property (@(posedge clk_sys) disable iff (RESET)
		rsp_valid |-> has_cred)
		else $error("response sent without a response credit");

	a_buf_no_overflow : assert property (@(posedge clk_sys) disable iff (RESET)
		(push && !pop) |-> (buf_cnt < CNT_W'(MAP_CREDITS)))
		else $error("result buffer overflow");

endmodule

`default_nettype wire

// File: wram_fill_gen.sv
/*
 * Work RAM clear at the start of every download.
 * One byte is written every second cycle over the whole address
 * range. FILL_ADDR_BITS must be at least 10, the patterns use
 * address bits 9, 8, 2 and 0.
 */
`timescale 1ns/10ps
`default_nettype none

module wram_fill_gen import cart_pkg::*; #(
	parameter int FILL_ADDR_BITS = 18
) (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      dl_active,
	input  fill_pattern_e             fill_pattern,
	output logic                      clearing,
	output logic                      fill_wr,
	output logic [FILL_ADDR_BITS-1:0] fill_addr,
	output logic [7:0]                fill_data
);

	typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_WAIT} fill_state_e;

	fill_state_e state;
	logic        dl_active_q;

	assign clearing = (state != ST_IDLE);
	assign fill_wr  = (state == ST_WRITE);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state       <= ST_IDLE;
			dl_active_q <= 1'b0;
			fill_addr   <= '0;
		end else begin
			dl_active_q <= dl_active;
			case (state)
				ST_WRITE: state <= (&fill_addr) ? ST_IDLE : ST_WAIT;
				ST_WAIT: begin
					state     <= ST_WRITE;
					fill_addr <= fill_addr + 1'b1;
				end
				default: fill_addr <= '0;
			endcase
			// Download start restarts the sweep from zero
			if (dl_active && !dl_active_q) begin
				state     <= ST_WRITE;
				fill_addr <= '0;
			end
		end
	end

	always_comb begin
		case (fill_pattern)
			FILL_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			FILL_00FF: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			FILL_55:   fill_data = 8'h55;
			default:   fill_data = 8'hFF;
		endcase
	end

	a_wr_in_clear : assert property (@(posedge clk_sys) disable iff (RESET)
		fill_wr |-> clearing)
		else $error("fill write outside of a clear");

endmodule

`default_nettype wire

// File: cart_loader_top.sv
/*
 * Cartridge loading path.
 * Header parser feeds the mirror stage, which feeds the lookup
 * mapper. The RAM clear runs beside them off the same download
 * strobe. Everything runs on clk_sys with a synchronous RESET.
 */
`timescale 1ns/10ps
`default_nettype none

module cart_loader_top import cart_pkg::*; #(
	parameter int MAP_CREDITS    = 4,
	parameter int FILL_ADDR_BITS = 18
) (
	input  logic                      clk_sys,
	input  logic                      RESET,
	// Download stream and menu settings
	input  logic                      dl_active,
	input  dl_word_t                  dl,
	input  hdr_mode_e                 hdr_mode,
	input  region_sel_e               region_sel,
	input  fill_pattern_e             fill_pattern,
	output cart_info_t                cart_info,
	// ROM lookup
	input  logic                      req_valid,
	input  rom_addr_t                 req_addr,
	output logic                      req_credit,
	output logic                      rsp_valid,
	output rom_addr_t                 rsp_addr,
	input  logic                      rsp_credit,
	// Work RAM clear
	output logic                      clearing,
	output logic                      fill_wr,
	output logic [FILL_ADDR_BITS-1:0] fill_addr,
	output logic [7:0]                fill_data
);

	logic        dl_end;
	mirror_cfg_t mirror;

	cart_header_parser cart_header_parser_inst (
		.clk_sys(clk_sys), .RESET(RESET), .dl_active(dl_active), .dl(dl),
		.hdr_mode(hdr_mode), .region_sel(region_sel),
		.cart_info(cart_info), .dl_end(dl_end)
	);

	rom_mirror_config rom_mirror_config_inst (
		.clk_sys(clk_sys), .RESET(RESET), .dl_active(dl_active),
		.dl_end(dl_end), .dl(dl), .mirror(mirror)
	);

	rom_addr_mapper #(.MAP_CREDITS(MAP_CREDITS)) rom_addr_mapper_inst (
		.clk_sys(clk_sys), .RESET(RESET), .mirror(mirror),
		.req_valid(req_valid), .req_addr(req_addr), .req_credit(req_credit),
		.rsp_valid(rsp_valid), .rsp_addr(rsp_addr), .rsp_credit(rsp_credit)
	);

	wram_fill_gen #(.FILL_ADDR_BITS(FILL_ADDR_BITS)) wram_fill_gen_inst (
		.clk_sys(clk_sys), .RESET(RESET), .dl_active(dl_active),
		.fill_pattern(fill_pattern), .clearing(clearing), .fill_wr(fill_wr),
		.fill_addr(fill_addr), .fill_data(fill_data)
	);

endmodule

`default_nettype wire

// File: tb_cart_model.svh
/*
 * Reference model for the cartridge loader testbench.
 * Beats must be fed in download order, the header word at address 0
 * resets the size codes. Included inside the testbench module and
 * relies on cart_pkg being imported there.
 */
`ifndef TB_CART_MODEL_SVH
`define TB_CART_MODEL_SVH

logic [7:0]  m_type     = '0;
logic [3:0]  m_rom_code = '0;
logic [3:0]  m_ram_code = '0;
logic        m_region   = 1'b0;
logic [23:0] m_file_sz  = '0;
logic        m_mir_en   = 1'b0;
logic [23:0] m_split    = '0;
logic [23:0] m_rmask    = '0;

function automatic logic [23:0] size_mask(input logic [3:0] code);
	return (24'd1024 << code) - 24'd1;
endfunction

function automatic logic [24:0] mode_info_addr(input hdr_mode_e mode);
	case (mode)
		HDR_LOROM:   return LOROM_INFO_ADDR;
		HDR_HIROM:   return HIROM_INFO_ADDR;
		default:     return EXHIROM_INFO_ADDR;
	endcase
endfunction

// One counted download beat
task automatic model_beat(input hdr_mode_e mode, input logic [24:0] addr,
		input logic [15:0] data);
	logic forced;
	forced = (mode == HDR_LOROM) || (mode == HDR_HIROM) || (mode == HDR_EXHIROM);
	if (addr == 25'd0) begin
		m_rom_code = ROM_SIZE_DEFAULT;
		m_ram_code = 4'd0;
		if (mode == HDR_AUTO && data[7:0] != 8'd0) begin
			m_ram_code = data[7:4];
			m_rom_code = data[3:0];
		end
		case (mode)
			HDR_AUTO:    m_type = data[15:8];
			HDR_HIROM:   m_type = 8'd1;
			HDR_EXHIROM: m_type = 8'd2;
			default:     m_type = 8'd0;
		endcase
	end
	if (addr == 25'd2)
		m_region = data[8];
	if (forced && addr == mode_info_addr(mode))
		m_rom_code = data[11:8];
	if (forced && addr == mode_info_addr(mode) + 25'd2)
		m_ram_code = data[3:0];
	if (addr == 25'd8)
		m_file_sz[15:0] = data;
	if (addr == 25'd10)
		m_file_sz[23:16] = data[7:0];
endtask

// Mirror window once the file is complete
task automatic model_end();
	logic found;
	m_mir_en = (m_file_sz & (m_file_sz - 24'd1)) != 24'd0;
	m_split  = MIRROR_MIN_SPLIT;
	found    = 1'b0;
	for (int b = 23; b >= 19; b--) begin
		if (m_file_sz[b] && !found) begin
			m_split = 24'd1 << b;
			found   = 1'b1;
		end
	end
	m_rmask = m_file_sz - m_split - 24'd1;
endtask

function automatic rom_addr_t mapped_addr(input rom_addr_t a);
	if (m_mir_en && (a & m_split) != 24'd0)
		return m_split | (a & m_rmask);
	return a;
endfunction

function automatic logic pal_for(input region_sel_e sel);
	case (sel)
		REG_NTSC: return 1'b0;
		REG_PAL:  return 1'b1;
		default:  return m_region;
	endcase
endfunction

function automatic logic [7:0] fill_byte(input fill_pattern_e p, input logic [31:0] a);
	case (p)
		FILL_9966: return (a[8] != a[2]) ? 8'h66 : 8'h99;
		FILL_00FF: return (a[9] != a[0]) ? 8'hFF : 8'h00;
		FILL_55:   return 8'h55;
		default:   return 8'hFF;
	endcase
endfunction

`endif

// File: tb_cart_loader.sv
/*
 * Testbench for the cartridge loading path.
 * Downloads are sparse. They carry the first header words plus the
 * info words of every forced mode, with idle beats in between.
 * The RAM clear is shortened to 1024 addresses. Stops at the first
 * mismatch.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_cart_loader import cart_pkg::*; ();

	localparam int N_CREDITS   = 4;
	localparam int FILL_BITS   = 10;
	localparam int N_DOWNLOADS = 10;
	localparam int N_HDR_WORDS = 16;
	localparam int N_BEATS     = N_HDR_WORDS + 6;
	localparam int N_LOOKUPS   = 24;
	localparam int FILL_WRITES = 1 << FILL_BITS;
	localparam int WATCHDOG_CYCLES = (N_DOWNLOADS + 1) *
		(N_BEATS * 4 + 2 * FILL_WRITES + 2 * N_LOOKUPS * 16 + 64);

	logic                 clk_sys;
	logic                 RESET;
	logic                 dl_active;
	dl_word_t             dl;
	hdr_mode_e            hdr_mode;
	region_sel_e          region_sel;
	fill_pattern_e        fill_pattern;
	cart_info_t           cart_info;
	logic                 req_valid;
	rom_addr_t            req_addr;
	logic                 req_credit;
	logic                 rsp_valid;
	rom_addr_t            rsp_addr;
	logic                 rsp_credit;
	logic                 clearing;
	logic                 fill_wr;
	logic [FILL_BITS-1:0] fill_addr;
	logic [7:0]           fill_data;

	integer    seed = 32'hbc29_cd93;
	string     test_name = "reset";
	int        err_count = 0;
	int        cycle = 0;
	int        clears_done = 0;
	int        fill_count = 0;
	int        last_wr_cycle = 0;
	logic      clearing_q = 1'b0;
	bit        lookup_run = 1'b0;
	bit        back_pressure = 1'b0;
	int        req_left = 0;
	int        req_credits = N_CREDITS;
	int        dut_rsp_cred = N_CREDITS;
	int        rsp_owed = 0;
	int        n_req_credit = 0;
	int        n_rsp = 0;
	rom_addr_t exp_q[$];
	int        exp_t[$];

	`include "tb_cart_model.svh"

	cart_loader_top #(.MAP_CREDITS(N_CREDITS), .FILL_ADDR_BITS(FILL_BITS)) cart_loader_top_inst (
		.clk_sys(clk_sys), .RESET(RESET), .dl_active(dl_active), .dl(dl),
		.hdr_mode(hdr_mode), .region_sel(region_sel), .fill_pattern(fill_pattern),
		.cart_info(cart_info), .req_valid(req_valid), .req_addr(req_addr),
		.req_credit(req_credit), .rsp_valid(rsp_valid), .rsp_addr(rsp_addr),
		.rsp_credit(rsp_credit), .clearing(clearing), .fill_wr(fill_wr),
		.fill_addr(fill_addr), .fill_data(fill_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	task automatic report_error(input string what);
		err_count++;
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_val(input string test, input string field,
			input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else
			report_error($sformatf("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h",
				test, field, exp, act));
	endtask

	// ====================================================================
	// Lookup requester and response consumer
	// ====================================================================

	always @(posedge clk_sys) begin
		if (lookup_run && req_left > 0 && req_credits > 0 && ($random(seed) & 3) != 0) begin
			req_valid <= 1'b1;
			req_addr  <= rom_addr_t'($random(seed));
			req_credits--;
			req_left--;
		end else begin
			req_valid <= 1'b0;
		end
		// Withheld credits trickle back at random under back-pressure
		if (rsp_owed > 0 && (!back_pressure || ($random(seed) & 3) == 0)) begin
			rsp_credit <= 1'b1;
			rsp_owed--;
		end else begin
			rsp_credit <= 1'b0;
		end
	end

	// ====================================================================
	// Output monitor sampled mid-cycle
	// ====================================================================

	always @(negedge clk_sys) begin
		rom_addr_t exp_addr;
		int        exp_cycle;
		cycle++;
		if (!RESET) begin
			if (req_valid) begin
				exp_q.push_back(mapped_addr(req_addr));
				exp_t.push_back(cycle);
			end
			if (req_credit) begin
				req_credits++;
				n_req_credit++;
				assert (req_credits <= N_CREDITS) else
					report_error("mapper returned more request credits than were spent");
			end
			if (rsp_valid) begin
				assert (dut_rsp_cred > 0) else
					report_error("mapper answered without holding a response credit");
				assert (exp_q.size() > 0) else
					report_error("mapper answered with no request outstanding");
				exp_addr  = exp_q.pop_front();
				exp_cycle = exp_t.pop_front();
				check_val(test_name, "rsp_addr", exp_addr, rsp_addr);
				if (!back_pressure)
					check_val(test_name, "latency", 2, cycle - exp_cycle);
				dut_rsp_cred--;
				rsp_owed++;
				n_rsp++;
			end
			if (rsp_credit)
				dut_rsp_cred++;

			// RAM clear sweep
			if (fill_wr) begin
				if (fill_count > 0)
					check_val("ram clear", "write spacing", 2, cycle - last_wr_cycle);
				check_val("ram clear", "fill_addr", fill_count, fill_addr);
				check_val("ram clear", "fill_data", fill_byte(fill_pattern, fill_count), fill_data);
				fill_count++;
				last_wr_cycle = cycle;
			end
			if (clearing_q && !clearing) begin
				check_val("ram clear", "write count", FILL_WRITES, fill_count);
				fill_count = 0;
				clears_done++;
			end
		end
		clearing_q = clearing;
	end

	// ====================================================================
	// Test sequences
	// ====================================================================

	task automatic run_download(input hdr_mode_e mode, input bit pow2, input fill_pattern_e pat);
		logic [24:0] addrs [N_BEATS];
		logic [15:0] words [N_BEATS];
		logic [31:0] r;
		logic [23:0] sz;
		int          target;
		int          gap;
		target    = clears_done + 1;
		test_name = (mode == HDR_AUTO) ? "auto header" : "override header";
		for (int i = 0; i < N_HDR_WORDS; i++)
			addrs[i] = 25'(2 * i);
		addrs[N_HDR_WORDS]     = LOROM_INFO_ADDR;
		addrs[N_HDR_WORDS + 1] = LOROM_INFO_ADDR + 25'd2;
		addrs[N_HDR_WORDS + 2] = HIROM_INFO_ADDR;
		addrs[N_HDR_WORDS + 3] = HIROM_INFO_ADDR + 25'd2;
		addrs[N_HDR_WORDS + 4] = EXHIROM_INFO_ADDR;
		addrs[N_HDR_WORDS + 5] = EXHIROM_INFO_ADDR + 25'd2;
		for (int i = 0; i < N_BEATS; i++)
			words[i] = 16'($random(seed));
		if (($random(seed) & 3) == 0)
			words[0][7:0] = 8'h00;
		// File size in the words at byte addresses 8 and 10
		r  = $random(seed);
		sz = r[23:0] >> ($random(seed) & 7);
		if (pow2)
			sz = 24'd1 << (10 + (($random(seed) & 15) % 14));
		words[4]      = sz[15:0];
		words[5][7:0] = sz[23:16];

		@(posedge clk_sys);
		hdr_mode     <= mode;
		fill_pattern <= pat;
		@(posedge clk_sys);
		dl_active <= 1'b1;
		m_file_sz = '0;
		for (int i = 0; i < N_BEATS; i++) begin
			@(posedge clk_sys);
			dl <= '{wr: 1'b1, addr: addrs[i], data: words[i]};
			model_beat(mode, addrs[i], words[i]);
			gap = $random(seed) & 3;
			repeat (gap) begin
				@(posedge clk_sys);
				dl <= '{wr: 1'b0, addr: 25'($random(seed)), data: 16'($random(seed))};
			end
		end
		@(posedge clk_sys);
		dl        <= '0;
		dl_active <= 1'b0;
		model_end();

		wait (clears_done == target);
		check_val(test_name, "rom_type", m_type, cart_info.rom_type);
		check_val(test_name, "rom_mask", size_mask(m_rom_code), cart_info.rom_mask);
		check_val(test_name, "ram_mask", (m_ram_code == 4'd0) ? 24'd0 : size_mask(m_ram_code),
			cart_info.ram_mask);
		check_val(test_name, "ram_size", m_ram_code, cart_info.ram_size);
	endtask

	task automatic check_region();
		region_sel_e sel;
		int          start;
		test_name = "region";
		start     = ($random(seed) & 32'h7fff) % 3;
		for (int k = 0; k < 3; k++) begin
			sel = region_sel_e'((start + k) % 3);
			@(posedge clk_sys);
			region_sel <= sel;
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_val(test_name, "pal", pal_for(sel), cart_info.pal);
		end
	endtask

	task automatic run_lookups(input string name, input bit bp);
		int target;
		target        = n_rsp + N_LOOKUPS;
		test_name     = name;
		back_pressure = bp;
		req_left      = N_LOOKUPS;
		lookup_run    = 1'b1;
		wait (n_rsp == target && dut_rsp_cred == N_CREDITS);
		lookup_run = 1'b0;
		check_val(name, "req_credit pulses", n_rsp, n_req_credit);
	endtask

	initial begin
		RESET        = 1'b1;
		dl_active    = 1'b0;
		dl           = '0;
		hdr_mode     = HDR_AUTO;
		region_sel   = REG_AUTO;
		fill_pattern = FILL_9966;
		req_valid    = 1'b0;
		req_addr     = '0;
		rsp_credit   = 1'b0;
		repeat (8) @(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		check_val("reset", "req_credit", 0, req_credit);
		check_val("reset", "rsp_valid", 0, rsp_valid);
		check_val("reset", "clearing", 0, clearing);
		check_val("reset", "fill_wr", 0, fill_wr);
		// No mirror yet so addresses pass unchanged
		run_lookups("lookup after reset", 1'b0);

		for (int i = 0; i < N_DOWNLOADS; i++) begin
			run_download(hdr_mode_e'(i % 5), (i % 3) == 2, fill_pattern_e'(i % 4));
			check_region();
			run_lookups("mirror lookup", 1'b0);
			run_lookups("back-pressure", 1'b1);
		end
		check_val("ram clear", "clear count", N_DOWNLOADS, clears_done);

		if (err_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		report_error("Watchdog timeout, the run did not finish in the expected time");
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
cart_pkg.sv
cart_header_parser.sv
rom_mirror_config.sv
rom_addr_mapper.sv
wram_fill_gen.sv
cart_loader_top.sv
tb_cart_loader.sv

// File: Bender.yml
package:
  name: cart_loader

sources:
  - files:
      - cart_pkg.sv
      - cart_header_parser.sv
      - rom_mirror_config.sv
      - rom_addr_mapper.sv
      - wram_fill_gen.sv
      - cart_loader_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cart_loader.sv
